/* graph_arbiter_settings.svh */
// Graph arbiter build settings
// CU count, buffer depths and field widths shared by the RTL and the testbench

`ifndef GRAPH_ARBITER_SETTINGS_SVH
`define GRAPH_ARBITER_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Compute units
//////////////////////////////////////////////////////////////////////

`define GA_NUM_GRAPH_CU 4

// Vertex units behind each graph CU, used by the enable decode
`define GA_VERTEX_CU_PER_GRAPH_CU 2

//////////////////////////////////////////////////////////////////////
// Buffers
//////////////////////////////////////////////////////////////////////

`define GA_CMD_FIFO_DEPTH 16
`define GA_VERTEX_FIFO_DEPTH 16

// Free entries left when almost-full rises
`define GA_ALMOST_FULL_MARGIN 2

// Field widths
`define GA_ADDR_BITS 48
`define GA_VERTEX_BITS 32
`define GA_EDGE_BITS 32

`endif

/* graph_arbiter_pkg.sv */
// Graph arbiter shared types
// Command, response, job, configuration and buffer status words
// passed between the arbiter blocks and the compute units

`include "graph_arbiter_settings.svh"

package graph_arbiter_pkg;

	// Index of one graph CU
	typedef logic [$clog2(`GA_NUM_GRAPH_CU)-1:0] cu_id_t;

	// Read command from a CU toward memory, size in bytes
	typedef struct packed {
		logic                     valid;
		cu_id_t                   cu_id;
		logic [`GA_ADDR_BITS-1:0] address;
		logic [7:0]               size;
	} read_command_t;

	// Memory read response, routed back by cu_id
	typedef struct packed {
		logic       valid;
		cu_id_t     cu_id;
		logic [7:0] tag;
		logic [1:0] status;
	} read_response_t;

	// One vertex job handed to a CU
	typedef struct packed {
		logic                       valid;
		logic [`GA_VERTEX_BITS-1:0] vertex_id;
		logic [`GA_EDGE_BITS-1:0]   out_degree;
		logic [`GA_EDGE_BITS-1:0]   first_edge;
	} vertex_job_t;

	// Configuration word, active unit count in the low half
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] active_units;
	} config_t;

	typedef struct packed {
		logic full;
		logic almost_full;
		logic empty;
	} fifo_status_t;

endpackage

/* sync_fifo.sv */
// Synchronous FIFO
// Circular buffer with an occupancy count, giving full, almost-full and
// empty. The head word is visible on data_out without a pop

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module sync_fifo import graph_arbiter_pkg::*; #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output fifo_status_t     status
);

	localparam int PTR_BITS = $clog2(DEPTH);

	logic [WIDTH-1:0]    mem [0:DEPTH-1];
	logic [PTR_BITS-1:0] write_ptr;
	logic [PTR_BITS-1:0] read_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	// Push into a full buffer and pop from an empty one are dropped
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	assign status = '{
		full:        (count == (PTR_BITS+1)'(DEPTH)),
		almost_full: (count >= (PTR_BITS+1)'(DEPTH - `GA_ALMOST_FULL_MARGIN)),
		empty:       (count == '0)
	};

	assign data_out = mem[read_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[write_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end else begin
			if (do_push) begin
				write_ptr <= (write_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			end
			if (do_pop) begin
				read_ptr <= (read_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count unchanged
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* round_robin_arbiter.sv */
// Round-robin arbiter for CU read commands
// Registers one valid command per cycle toward the command buffer and
// returns a one-hot grant to the winning CU

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module round_robin_arbiter import graph_arbiter_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  read_command_t               command_in [0:`GA_NUM_GRAPH_CU-1],
	input  logic                        blocked,
	output read_command_t               command_out,
	output logic [`GA_NUM_GRAPH_CU-1:0] grant
);

	// A granted command stays visible for this many picks
	// Grant output register, CU reaction and input register
	localparam int HOLDOFF_CYCLES = 3;
	localparam int HOLDOFF_BITS   = $clog2(HOLDOFF_CYCLES + 1);

	logic [HOLDOFF_BITS-1:0]     holdoff [0:`GA_NUM_GRAPH_CU-1];
	logic [`GA_NUM_GRAPH_CU-1:0] eligible;
	cu_id_t                      last_winner;
	cu_id_t                      winner;
	logic                        found;
	logic                        take;

	always_comb begin
		for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
			eligible[lane] = command_in[lane].valid && (holdoff[lane] == '0);
		end
	end

	// First eligible CU after the last winner
	always_comb begin : pick
		int candidate;
		found  = 1'b0;
		winner = last_winner;
		for (int offset = 1; offset <= `GA_NUM_GRAPH_CU; offset++) begin
			candidate = (int'(last_winner) + offset) % `GA_NUM_GRAPH_CU;
			if (!found && eligible[candidate]) begin
				found  = 1'b1;
				winner = cu_id_t'(candidate);
			end
		end
	end

	assign take = enabled && !blocked && found;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// CU 0 goes first after reset
			last_winner <= cu_id_t'(`GA_NUM_GRAPH_CU - 1);
			command_out <= '0;
			grant       <= '0;
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				holdoff[lane] <= '0;
			end
		end else begin
			command_out <= take ? command_in[winner] : '0;
			grant       <= take ? (`GA_NUM_GRAPH_CU'(1) << winner) : '0;
			if (take) begin
				last_winner <= winner;
			end
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				if (take && (winner == cu_id_t'(lane))) begin
					holdoff[lane] <= HOLDOFF_BITS'(HOLDOFF_CYCLES);
				end else if (holdoff[lane] != '0) begin
					holdoff[lane] <= holdoff[lane] - 1'b1;
				end
			end
		end
	end

endmodule

/* response_router.sv */
// Read response router
// Registered demultiplexer that steers each memory read response onto
// the lane of the CU named in it. All other lanes stay idle

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module response_router import graph_arbiter_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  read_response_t response_in,
	output read_response_t response_cu [0:`GA_NUM_GRAPH_CU-1]
);

	logic [`GA_NUM_GRAPH_CU-1:0] lane_hit;

	// One-hot lane decode of cu_id
	always_comb begin
		for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
			lane_hit[lane] = response_in.valid && (response_in.cu_id == cu_id_t'(lane));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				response_cu[lane] <= '0;
			end
		end else begin
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				// Idle lanes are cleared, so a response lasts one cycle
				response_cu[lane] <= lane_hit[lane] ? response_in : '0;
			end
		end
	end

endmodule

/* vertex_job_dispatcher.sv */
// Vertex job dispatcher
// Buffers vertex jobs from the host, asks for more while there is room,
// and hands one job per cycle to a requesting CU in rotating order

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module vertex_job_dispatcher import graph_arbiter_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  vertex_job_t                 job_in,
	output logic                        job_request,
	input  logic [`GA_NUM_GRAPH_CU-1:0] request_cu,
	output vertex_job_t                 job_cu [0:`GA_NUM_GRAPH_CU-1]
);

	vertex_job_t  head;
	fifo_status_t status;
	logic         pop;
	cu_id_t       last_served;
	cu_id_t       next_served;
	logic         found;

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(`GA_VERTEX_FIFO_DEPTH)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_in.valid),
		.data_in (job_in),
		.pop     (pop),
		.data_out(head),
		.status  (status)
	);

	// Next requester after the CU served last
	always_comb begin : select
		int candidate;
		found       = 1'b0;
		next_served = last_served;
		for (int offset = 1; offset <= `GA_NUM_GRAPH_CU; offset++) begin
			candidate = (int'(last_served) + offset) % `GA_NUM_GRAPH_CU;
			if (!found && request_cu[candidate]) begin
				found       = 1'b1;
				next_served = cu_id_t'(candidate);
			end
		end
	end

	assign pop = enabled && !status.empty && found;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_served <= cu_id_t'(`GA_NUM_GRAPH_CU - 1);
			job_request <= 1'b0;
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				job_cu[lane] <= '0;
			end
		end else begin
			// Host keeps sending while the buffer has room
			job_request <= !status.almost_full;
			if (pop) begin
				last_served <= next_served;
			end
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				job_cu[lane] <= (pop && (next_served == cu_id_t'(lane))) ? head : '0;
			end
		end
	end

endmodule

/* done_counter_reduce.sv */
// Done counter reduction
// Registered totals of the per-CU vertex and edge done counters

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module done_counter_reduce (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  logic [`GA_VERTEX_BITS-1:0] vertex_done_cu [0:`GA_NUM_GRAPH_CU-1],
	input  logic [`GA_EDGE_BITS-1:0]   edge_done_cu [0:`GA_NUM_GRAPH_CU-1],
	output logic [`GA_VERTEX_BITS-1:0] vertex_done_total,
	output logic [`GA_EDGE_BITS-1:0]   edge_done_total
);

	logic [`GA_VERTEX_BITS-1:0] vertex_sum;
	logic [`GA_EDGE_BITS-1:0]   edge_sum;

	// Totals wrap at the counter width
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
			vertex_sum = vertex_sum + vertex_done_cu[lane];
			edge_sum   = edge_sum + edge_done_cu[lane];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_total <= '0;
			edge_done_total   <= '0;
		end else if (enabled) begin
			vertex_done_total <= vertex_sum;
			edge_done_total   <= edge_sum;
		end
	end

endmodule

/* graph_arbiter_control.sv */
// Graph arbiter top level
// Sits between the shared memory port and the graph CUs. Registers all
// inputs, decodes the CU enables, routes read responses, arbitrates read
// commands into one buffer and dispatches vertex jobs

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module graph_arbiter_control import graph_arbiter_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  config_t                     cu_configure,
	output logic [`GA_NUM_GRAPH_CU-1:0] cu_enable,
	input  read_response_t              read_response_in,
	output read_response_t              read_response_cu [0:`GA_NUM_GRAPH_CU-1],
	input  read_command_t               read_command_cu [0:`GA_NUM_GRAPH_CU-1],
	output logic [`GA_NUM_GRAPH_CU-1:0] read_command_grant_cu,
	output read_command_t               read_command_out,
	output logic                        read_command_bus_request,
	input  logic                        read_command_bus_grant,
	input  vertex_job_t                 vertex_job_in,
	output logic                        vertex_job_request,
	input  logic [`GA_NUM_GRAPH_CU-1:0] vertex_job_request_cu,
	output vertex_job_t                 vertex_job_cu [0:`GA_NUM_GRAPH_CU-1],
	input  logic [`GA_VERTEX_BITS-1:0]  vertex_done_cu [0:`GA_NUM_GRAPH_CU-1],
	input  logic [`GA_EDGE_BITS-1:0]    edge_done_cu [0:`GA_NUM_GRAPH_CU-1],
	output logic [`GA_VERTEX_BITS-1:0]  vertex_done_total,
	output logic [`GA_EDGE_BITS-1:0]    edge_done_total
);

	logic                        enabled;
	config_t                     config_latched;
	read_response_t              response_q;
	read_command_t               command_q [0:`GA_NUM_GRAPH_CU-1];
	logic                        bus_grant_q;
	vertex_job_t                 job_q;
	logic [`GA_NUM_GRAPH_CU-1:0] job_request_q;
	logic [`GA_VERTEX_BITS-1:0]  vertex_done_q [0:`GA_NUM_GRAPH_CU-1];
	logic [`GA_EDGE_BITS-1:0]    edge_done_q [0:`GA_NUM_GRAPH_CU-1];

	read_command_t               picked_command;
	logic [`GA_NUM_GRAPH_CU-1:0] arbiter_grant;
	read_command_t               command_head;
	fifo_status_t                command_status;
	logic                        command_pop;

	//////////////////////////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			config_latched <= '0;
			response_q     <= '0;
			bus_grant_q    <= 1'b0;
			job_q          <= '0;
			job_request_q  <= '0;
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				command_q[lane]     <= '0;
				vertex_done_q[lane] <= '0;
				edge_done_q[lane]   <= '0;
			end
		end else begin
			enabled <= enabled_in;
			// A zero word keeps the previous configuration
			if (cu_configure != '0) begin
				config_latched <= cu_configure;
			end
			response_q    <= read_response_in;
			bus_grant_q   <= read_command_bus_grant;
			job_q         <= vertex_job_in;
			job_request_q <= vertex_job_request_cu;
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				command_q[lane]     <= read_command_cu[lane];
				vertex_done_q[lane] <= vertex_done_cu[lane];
				edge_done_q[lane]   <= edge_done_cu[lane];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read command path
	//////////////////////////////////////////////////////////////////////

	// CU picks stop at almost-full, which covers the pick in flight
	round_robin_arbiter command_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.command_in (command_q),
		.blocked    (command_status.almost_full),
		.command_out(picked_command),
		.grant      (arbiter_grant)
	);

	sync_fifo #(
		.WIDTH($bits(read_command_t)),
		.DEPTH(`GA_CMD_FIFO_DEPTH)
	) command_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (picked_command.valid),
		.data_in (picked_command),
		.pop     (command_pop),
		.data_out(command_head),
		.status  (command_status)
	);

	// Bus grant pops the head
	assign command_pop = enabled && bus_grant_q && !command_status.empty;

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_enable                <= '0;
			read_command_grant_cu    <= '0;
			read_command_out         <= '0;
			read_command_bus_request <= 1'b0;
		end else begin
			// CU i runs when its first vertex unit is within the active count
			for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
				cu_enable[lane] <= 32'(lane * `GA_VERTEX_CU_PER_GRAPH_CU)
					< config_latched.active_units;
			end
			read_command_grant_cu    <= arbiter_grant;
			read_command_out         <= command_pop ? command_head : '0;
			read_command_bus_request <= !command_status.empty;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Responses, vertex jobs and done counts
	//////////////////////////////////////////////////////////////////////

	response_router read_router (
		.clock      (clock),
		.rstn       (rstn),
		.response_in(response_q),
		.response_cu(read_response_cu)
	);

	vertex_job_dispatcher job_dispatcher (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.job_in     (job_q),
		.job_request(vertex_job_request),
		.request_cu (job_request_q),
		.job_cu     (vertex_job_cu)
	);

	done_counter_reduce done_reduce (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.vertex_done_cu   (vertex_done_q),
		.edge_done_cu     (edge_done_q),
		.vertex_done_total(vertex_done_total),
		.edge_done_total  (edge_done_total)
	);

endmodule

/* graph_arbiter_assertions.sv */
// Graph arbiter assertions
// Concurrent checks on CU grants, vertex job hand-out and reset state

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module graph_arbiter_assertions import graph_arbiter_pkg::*; (
	input logic                        clock,
	input logic                        rstn,
	input logic [`GA_NUM_GRAPH_CU-1:0] read_command_grant_cu,
	input read_command_t               read_command_out,
	input read_response_t              read_response_cu [0:`GA_NUM_GRAPH_CU-1],
	input vertex_job_t                 vertex_job_cu [0:`GA_NUM_GRAPH_CU-1]
);

	logic [`GA_NUM_GRAPH_CU-1:0] job_valid;
	logic [`GA_NUM_GRAPH_CU-1:0] response_valid;
	int                          failure_count = 0;

	always_comb begin
		for (int lane = 0; lane < `GA_NUM_GRAPH_CU; lane++) begin
			job_valid[lane]      = vertex_job_cu[lane].valid;
			response_valid[lane] = read_response_cu[lane].valid;
		end
	end

	grant_one_hot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(read_command_grant_cu))
		else begin
			failure_count++;
			$error("read command grant set for more than one CU");
		end

	// One job leaves the buffer per cycle
	single_job: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(job_valid))
		else begin
			failure_count++;
			$error("more than one vertex job valid in one cycle");
		end

	quiet_in_reset: assert property (@(posedge clock)
		!rstn |-> (!read_command_out.valid && job_valid == '0
			&& response_valid == '0 && read_command_grant_cu == '0))
		else begin
			failure_count++;
			$error("output valid set during reset");
		end

endmodule

bind graph_arbiter_control graph_arbiter_assertions assertions_i (.*);

/* graph_arbiter_tb.sv */
// Graph arbiter testbench
// Directed tests for enable decode, response routing, read command
// arbitration with back-pressure, vertex job dispatch and done totals

`timescale 1ns/1ps
`include "graph_arbiter_settings.svh"

module graph_arbiter_tb import graph_arbiter_pkg::*; ();

	localparam int NUM_CU = `GA_NUM_GRAPH_CU;

	logic                       clock;
	logic                       rstn;
	logic                       enabled_in;
	config_t                    cu_configure;
	logic [NUM_CU-1:0]          cu_enable;
	read_response_t             read_response_in;
	read_response_t             read_response_cu [0:NUM_CU-1];
	read_command_t              read_command_cu [0:NUM_CU-1];
	logic [NUM_CU-1:0]          read_command_grant_cu;
	read_command_t              read_command_out;
	logic                       read_command_bus_request;
	logic                       read_command_bus_grant;
	vertex_job_t                vertex_job_in;
	logic                       vertex_job_request;
	logic [NUM_CU-1:0]          vertex_job_request_cu;
	vertex_job_t                vertex_job_cu [0:NUM_CU-1];
	logic [`GA_VERTEX_BITS-1:0] vertex_done_cu [0:NUM_CU-1];
	logic [`GA_EDGE_BITS-1:0]   edge_done_cu [0:NUM_CU-1];
	logic [`GA_VERTEX_BITS-1:0] vertex_done_total;
	logic [`GA_EDGE_BITS-1:0]   edge_done_total;

	int          error_count;
	int          pass_count;
	logic [31:0] rng_state;

	graph_arbiter_control graph_arbiter_control_i (.*);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	//////////////////////////////////////////////////////////////////////

	// xorshift32
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic read_command_t make_command(input int lane);
		read_command_t command;
		logic [31:0]   high;
		logic [31:0]   low;
		high = next_random();
		low  = next_random();
		command.valid   = 1'b1;
		command.cu_id   = cu_id_t'(lane);
		command.address = {high[15:0], low};
		command.size    = high[23:16];
		return command;
	endfunction

	function automatic vertex_job_t make_job();
		vertex_job_t job;
		job.valid      = 1'b1;
		job.vertex_id  = next_random();
		job.out_degree = next_random();
		job.first_edge = next_random();
		return job;
	endfunction

	task automatic note_failure(input string what);
		error_count++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic bits_match(input string name, input logic [NUM_CU-1:0] actual,
		input logic [NUM_CU-1:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %b expected %b", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic level_match(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %b expected %b", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic count_match(input string name, input logic [`GA_VERTEX_BITS-1:0] actual,
		input logic [`GA_VERTEX_BITS-1:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic edge_count_match(input string name, input logic [`GA_EDGE_BITS-1:0] actual,
		input logic [`GA_EDGE_BITS-1:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic command_match(input string name, input read_command_t actual,
		input read_command_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic response_match(input string name, input read_response_t actual,
		input read_response_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic job_match(input string name, input vertex_job_t actual,
		input vertex_job_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		bits_match("cu_enable", cu_enable, '0);
		bits_match("read_command_grant_cu", read_command_grant_cu, '0);
		level_match("read_command_bus_request", read_command_bus_request, 1'b0);
		level_match("vertex_job_request", vertex_job_request, 1'b0);
		command_match("read_command_out", read_command_out, '0);
		count_match("vertex_done_total", vertex_done_total, '0);
		edge_count_match("edge_done_total", edge_done_total, '0);
		for (int lane = 0; lane < NUM_CU; lane++) begin
			response_match($sformatf("read_response_cu[%0d]", lane), read_response_cu[lane], '0);
			job_match($sformatf("vertex_job_cu[%0d]", lane), vertex_job_cu[lane], '0);
		end
	endtask

	task automatic configure_enables();
		config_t setting;
		setting.flags        = next_random();
		setting.active_units = 32'd5;
		@(posedge clock);
		cu_configure <= setting;
		@(posedge clock);
		cu_configure <= '0;
		@(negedge clock);
		bits_match("cu_enable", cu_enable, '0);
		@(negedge clock);
		// Five units cover CUs 0 to 2
		bits_match("cu_enable", cu_enable, 4'b0111);
		// Zero word keeps the enables
		repeat (4) begin
			@(negedge clock);
			bits_match("cu_enable", cu_enable, 4'b0111);
		end
	endtask

	task automatic route_responses(input int count);
		read_response_t sent;
		read_response_t delay_1;
		read_response_t delay_2;
		read_response_t expected;
		logic [31:0]    rnd;
		sent    = '0;
		delay_1 = '0;
		for (int step = 0; step < count + 2; step++) begin
			rnd     = next_random();
			delay_2 = delay_1;
			delay_1 = sent;
			sent    = '0;
			// About one cycle in four stays idle
			if (step < count && rnd[1:0] != 2'b00) begin
				sent.valid  = 1'b1;
				sent.cu_id  = rnd[3:2];
				sent.tag    = rnd[15:8];
				sent.status = rnd[17:16];
			end
			@(posedge clock);
			read_response_in <= sent;
			@(negedge clock);
			for (int lane = 0; lane < NUM_CU; lane++) begin
				expected = (delay_2.valid && delay_2.cu_id == cu_id_t'(lane)) ? delay_2 : '0;
				response_match($sformatf("read_response_cu[%0d]", lane),
					read_response_cu[lane], expected);
			end
		end
	endtask

	// Bus grant stays low for the first stall cycles
	task automatic arbitrate_commands(input int per_cu, input int stall, input int limit);
		read_command_t     granted [$];
		read_command_t     current [0:NUM_CU-1];
		int                issued [0:NUM_CU-1];
		logic [NUM_CU-1:0] served;
		logic [NUM_CU-1:0] pending;
		logic              unfair;
		int                winner;
		int                received;
		int                step;
		int                first_grant;
		int                last_grant;
		for (int lane = 0; lane < NUM_CU; lane++) begin
			issued[lane]  = 0;
			current[lane] = make_command(lane);
		end
		served      = '0;
		received    = 0;
		step        = 0;
		first_grant = -1;
		last_grant  = -1;
		while (received < NUM_CU * per_cu && step < limit) begin
			@(posedge clock);
			read_command_bus_grant <= (step >= stall);
			for (int lane = 0; lane < NUM_CU; lane++) begin
				read_command_cu[lane] <= current[lane];
			end
			@(negedge clock);
			if (read_command_out.valid) begin
				if (granted.size() == 0) begin
					note_failure("read command came out without a matching CU grant");
				end else begin
					command_match("read_command_out", read_command_out, granted.pop_front());
				end
				received++;
			end
			if (step < stall) begin
				if (read_command_out.valid) begin
					note_failure("read command left the buffer without a bus grant");
				end
				if (first_grant >= 0 && step > first_grant) begin
					level_match("read_command_bus_request", read_command_bus_request, 1'b1);
				end
				if (granted.size() > `GA_CMD_FIFO_DEPTH) begin
					note_failure("more commands granted than the command buffer holds");
				end
				if (step == stall - 1 && last_grant >= stall - 10) begin
					note_failure("CU grants did not stop under back-pressure");
				end
			end
			winner = -1;
			for (int lane = NUM_CU - 1; lane >= 0; lane--) begin
				if (read_command_grant_cu[lane]) begin
					winner = lane;
				end
			end
			if (winner >= 0) begin
				for (int lane = 0; lane < NUM_CU; lane++) begin
					pending[lane] = current[lane].valid;
				end
				if (!pending[winner]) begin
					note_failure($sformatf("CU %0d granted with no command waiting", winner));
				end else begin
					// A second grant ends the round only if nobody else waits
					if (served[winner]) begin
						unfair = 1'b0;
						for (int lane = 0; lane < NUM_CU; lane++) begin
							if (lane != winner && pending[lane] && !served[lane]) begin
								unfair = 1'b1;
							end
						end
						if (unfair) begin
							note_failure($sformatf("CU %0d granted twice while another CU waited",
								winner));
						end
						served = '0;
					end
					served[winner] = 1'b1;
					granted.push_back(current[winner]);
					issued[winner]++;
					current[winner] = (issued[winner] < per_cu) ? make_command(winner) : '0;
					if (first_grant < 0) begin
						first_grant = step;
					end
					last_grant = step;
				end
			end
			step++;
		end
		if (received < NUM_CU * per_cu) begin
			note_failure("timed out waiting for read commands to leave the buffer");
		end
		for (int lane = 0; lane < NUM_CU; lane++) begin
			if (issued[lane] != per_cu) begin
				note_failure($sformatf("CU %0d got %0d grants for %0d commands",
					lane, issued[lane], per_cu));
			end
		end
	endtask

	task automatic dispatch_jobs(input int total, input int limit);
		vertex_job_t       expected [$];
		vertex_job_t       job;
		logic [NUM_CU-1:0] request_now;
		logic [NUM_CU-1:0] request_1;
		logic [NUM_CU-1:0] request_2;
		logic [31:0]       rnd;
		int                pushed;
		int                delivered;
		int                hits;
		int                step;
		request_now = '0;
		request_1   = '0;
		pushed      = 0;
		delivered   = 0;
		step        = 0;
		@(negedge clock);
		level_match("vertex_job_request", vertex_job_request, 1'b1);
		while (delivered < total && step < limit) begin
			request_2 = request_1;
			request_1 = request_now;
			rnd       = next_random();
			// No CU asks during the fill, then at least one always asks
			request_now = (step < 18) ? '0 : (rnd[NUM_CU-1:0] | (NUM_CU'(1) << rnd[5:4]));
			job = '0;
			if (pushed < total && (step < `GA_VERTEX_FIFO_DEPTH - `GA_ALMOST_FULL_MARGIN
				|| (step >= 18 && vertex_job_request))) begin
				job = make_job();
				expected.push_back(job);
				pushed++;
			end
			@(posedge clock);
			vertex_job_in         <= job;
			vertex_job_request_cu <= request_now;
			@(negedge clock);
			if (step == 15) begin
				level_match("vertex_job_request", vertex_job_request, 1'b1);
			end
			if (step == 17) begin
				level_match("vertex_job_request", vertex_job_request, 1'b0);
			end
			hits = 0;
			for (int lane = 0; lane < NUM_CU; lane++) begin
				if (vertex_job_cu[lane].valid) begin
					hits++;
					delivered++;
					if (!request_2[lane]) begin
						note_failure($sformatf("job delivered to CU %0d without a request", lane));
					end
					if (expected.size() == 0) begin
						note_failure("job delivered with no job pending");
					end else begin
						job_match($sformatf("vertex_job_cu[%0d]", lane), vertex_job_cu[lane],
							expected.pop_front());
					end
				end
			end
			if (hits > 1) begin
				note_failure("more than one vertex job delivered in one cycle");
			end
			step++;
		end
		@(posedge clock);
		vertex_job_request_cu <= '0;
		if (delivered < total) begin
			note_failure("timed out waiting for vertex jobs to reach the CUs");
		end
	endtask

	task automatic reduce_done_counts(input int count);
		logic [`GA_VERTEX_BITS-1:0] vertex_sum [0:2];
		logic [`GA_EDGE_BITS-1:0]   edge_sum [0:2];
		logic [`GA_VERTEX_BITS-1:0] vertex_value;
		logic [`GA_EDGE_BITS-1:0]   edge_value;
		vertex_sum[0] = '0;
		vertex_sum[1] = '0;
		edge_sum[0]   = '0;
		edge_sum[1]   = '0;
		for (int step = 0; step < count + 2; step++) begin
			vertex_sum[2] = vertex_sum[1];
			vertex_sum[1] = vertex_sum[0];
			edge_sum[2]   = edge_sum[1];
			edge_sum[1]   = edge_sum[0];
			vertex_sum[0] = '0;
			edge_sum[0]   = '0;
			@(posedge clock);
			for (int lane = 0; lane < NUM_CU; lane++) begin
				vertex_value = next_random();
				edge_value   = next_random();
				vertex_done_cu[lane] <= vertex_value;
				edge_done_cu[lane]   <= edge_value;
				vertex_sum[0] = vertex_sum[0] + vertex_value;
				edge_sum[0]   = edge_sum[0] + edge_value;
			end
			@(negedge clock);
			if (step >= 2) begin
				count_match("vertex_done_total", vertex_done_total, vertex_sum[2]);
				edge_count_match("edge_done_total", edge_done_total, edge_sum[2]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		error_count = 0;
		pass_count  = 0;
		rng_state   = 32'hb086be31;
		rstn                   <= 1'b0;
		enabled_in             <= 1'b0;
		cu_configure           <= '0;
		read_response_in       <= '0;
		read_command_bus_grant <= 1'b0;
		vertex_job_in          <= '0;
		vertex_job_request_cu  <= '0;
		for (int lane = 0; lane < NUM_CU; lane++) begin
			read_command_cu[lane] <= '0;
			vertex_done_cu[lane]  <= '0;
			edge_done_cu[lane]    <= '0;
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		idle_after_reset();
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		enabled_in <= 1'b1;
		configure_enables();
		route_responses(40);
		arbitrate_commands(4, 0, 200);
		arbitrate_commands(6, 40, 400);
		dispatch_jobs(34, 400);
		reduce_done_counts(20);
		error_count += graph_arbiter_control_i.assertions_i.failure_count;
		$display("Checks passed %0d, errors %0d", pass_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* graph_arbiter.f */
+incdir+.
graph_arbiter_pkg.sv
sync_fifo.sv
round_robin_arbiter.sv
response_router.sv
vertex_job_dispatcher.sv
done_counter_reduce.sv
graph_arbiter_control.sv
graph_arbiter_assertions.sv
graph_arbiter_tb.sv
